/* hw/agusec_pkg.sv */
`default_nettype none

package agusec_pkg;

  // capability pointer fields
  localparam int PTR_ADDR_LSB = 4;
  localparam int PTR_ADDR_MSB = 43;
  localparam int PTR_LOW_LSB  = 44;
  localparam int PTR_LOW_MSB  = 50;
  localparam int PTR_HI_LSB   = 51;
  localparam int PTR_HI_MSB   = 57;
  localparam int PTR_EXP_LSB  = 58;
  localparam int PTR_EXP_MSB  = 62;
  localparam int PTR_ON_LOW   = 63;

  localparam int PTR_W   = 64;
  localparam int GADDR_W = 40;
  localparam int BOUND_W = 7;
  localparam int EXP_W   = 5;
  localparam int WIN_W   = 8;
  localparam int CFG_W   = 32;

  typedef logic [PTR_W-1:0]   ptr_t;
  typedef logic [GADDR_W-1:0] gaddr_t;
  typedef logic [BOUND_W-1:0] bound_t;
  typedef logic [EXP_W-1:0]   exp_t;
  typedef logic [WIN_W-1:0]   win_t;
  typedef logic [CFG_W-1:0]   cfg_data_t;

  // every access is legal at this exponent
  localparam exp_t EXP_MAX = 5'd31;

  // register map
  localparam logic [1:0] CFG_CTRL   = 2'd0;
  localparam logic [1:0] CFG_COUNT  = 2'd1;
  localparam logic [1:0] CFG_PTR_LO = 2'd2;
  localparam logic [1:0] CFG_PTR_HI = 2'd3;

  localparam cfg_data_t COUNT_MAX = {CFG_W{1'b1}};

endpackage

`default_nettype wire

/* hw/agusec_check_upper3.sv */
`timescale 1ns/10ps
`default_nettype none

module agusec_check_upper3
  import agusec_pkg::*;
(
  input  ptr_t       ptr,
  input  gaddr_t     a,
  input  gaddr_t     b,
  output logic [2:0] pos_ack,
  output logic [2:0] neg_ack,
  output logic [1:0] pos_flip,
  output logic [1:0] neg_flip,
  output logic       nhi_less
);

  exp_t       exp;
  bound_t     low;
  bound_t     high;
  logic       on_low;
  logic       max_exp;
  logic       diff;
  logic [5:0] hsh;
  gaddr_t     mhi;
  gaddr_t     one_at;
  gaddr_t     gen;
  gaddr_t     prop;
  logic [GADDR_W:0] cy;
  logic       k;
  logic       eq_z;
  logic       eq_p1;
  logic       eq_m1;
  logic       eq_m2;
  logic [2:0] agree;

  assign exp     = ptr[PTR_EXP_MSB:PTR_EXP_LSB];
  assign low     = ptr[PTR_LOW_MSB:PTR_LOW_LSB];
  assign high    = ptr[PTR_HI_MSB:PTR_HI_LSB];
  assign on_low  = ptr[PTR_ON_LOW];
  assign max_exp = (exp == EXP_MAX);

  assign nhi_less = (high >= low);
  assign diff     = ~nhi_less;

  // first bit above the window
  assign hsh    = {1'b0, exp} + 6'd8;
  assign mhi    = {GADDR_W{1'b1}} << hsh;
  assign one_at = gaddr_t'(1) << hsh;

  assign gen  = a & b;
  assign prop = a ^ b;

  // carry out of the bits below and in the window, from generate and propagate
  always_comb begin
    cy[0] = 1'b0;
    for (int i = 0; i < GADDR_W; i++) begin
      cy[i+1] = gen[i] | (prop[i] & cy[i]);
    end
    k = cy[hsh];
  end

  // offset bits above the window against the small values a carry can produce
  assign eq_z  = ~|(b & mhi);
  assign eq_m1 = &(b | ~mhi);
  assign eq_p1 = ~|((b ^ one_at) & mhi);
  assign eq_m2 = ~|((b ^ (mhi ^ one_at)) & mhi);

  // upper part of the sum minus the upper part of a is b_hi + k,
  // which must equal the expected carry c
  // index 0 is c = 0, index 1 is c = +1, index 2 is c = -1
  assign agree[0] = k ? eq_m1 : eq_z;
  assign agree[1] = k ? eq_z  : eq_p1;
  assign agree[2] = k ? eq_m2 : eq_m1;

  assign pos_ack = agree & {3{~b[GADDR_W-1]}};
  assign neg_ack = agree & {3{b[GADDR_W-1]}};

  // wrapped bounds decide which correction the window may call for
  assign pos_flip[0] = diff & ~on_low;
  assign neg_flip[0] = diff & on_low;
  assign pos_flip[1] = max_exp;
  assign neg_flip[1] = ~max_exp;

endmodule

`default_nettype wire

/* hw/agusec_range.sv */
`timescale 1ns/10ps
`default_nettype none

module agusec_range
  import agusec_pkg::*;
(
  input  ptr_t   ptr,
  input  gaddr_t sum,
  input  logic   cin_secq,
  input  logic   diff,
  output logic   cout_secq
);

  exp_t         exp;
  win_t         low_w;
  win_t         high_w;
  gaddr_t       shifted;
  win_t         bits;
  logic [WIN_W:0] sub_low;
  logic [WIN_W:0] sub_high;
  logic         cout_low;
  logic         cout_hio;
  logic         lo_ok;
  logic         hi_ok;

  assign exp    = ptr[PTR_EXP_MSB:PTR_EXP_LSB];
  assign low_w  = {ptr[PTR_LOW_MSB:PTR_LOW_LSB], 1'b0};
  assign high_w = {ptr[PTR_HI_MSB:PTR_HI_LSB], 1'b1};

  assign shifted = sum >> exp;
  assign bits    = shifted[WIN_W-1:0];

  // carry out of bits - low is set when bits >= low
  assign sub_low  = {1'b0, bits} + {1'b0, ~low_w} + 9'd1;
  assign cout_low = sub_low[WIN_W];

  // carry out of high - bits is set when bits <= high
  assign sub_high = {1'b0, high_w} + {1'b0, ~bits} + 9'd1;
  assign cout_hio = sub_high[WIN_W];

  // with wrapped bounds either side alone is enough
  assign lo_ok = cout_low | (diff & cout_hio);
  assign hi_ok = cout_hio | (diff & cout_low);

  assign cout_secq = cin_secq & lo_ok & hi_ok;

endmodule

`default_nettype wire

/* hw/agusec_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module agusec_unit
  import agusec_pkg::*;
(
  input  logic   clk,
  input  logic   arst_n,
  input  logic   req,
  input  ptr_t   ptr,
  input  gaddr_t a,
  input  gaddr_t b,
  input  logic   check_en,
  output logic   rsp,
  output logic   legal,
  output logic   fault,
  output ptr_t   ptr_out
);

  // stage 1
  logic   v1;
  logic   en1;
  ptr_t   ptr1;
  gaddr_t a1;
  gaddr_t b1;
  gaddr_t s1;

  // stage 2 combinational
  logic [2:0] pos_ack;
  logic [2:0] neg_ack;
  logic [1:0] pos_flip;
  logic [1:0] neg_flip;
  logic       nhi_less;
  logic       win_ok;
  logic       ge_low;
  ptr_t       ptr_lo_only;
  logic [2:0] ack;
  logic       c_up;
  logic       c_dn;
  logic       agree;
  logic       legal_d;
  ptr_t       ptr_sum;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      v1  <= 1'b0;
      en1 <= 1'b1;
    end else begin
      v1 <= req;
      if (req) begin
        en1 <= check_en;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req) begin
      ptr1 <= ptr;
      a1   <= a;
      b1   <= b;
      s1   <= a + b;
    end
  end

  agusec_check_upper3 u_upper (
    .ptr      (ptr1),
    .a        (a1),
    .b        (b1),
    .pos_ack  (pos_ack),
    .neg_ack  (neg_ack),
    .pos_flip (pos_flip),
    .neg_flip (neg_flip),
    .nhi_less (nhi_less)
  );

  agusec_range u_range (
    .ptr       (ptr1),
    .sum       (s1),
    .cin_secq  (1'b1),
    .diff      (~nhi_less),
    .cout_secq (win_ok)
  );

  // an all-ones high bound leaves only the low bound test
  assign ptr_lo_only = {ptr1[PTR_W-1:PTR_HI_MSB+1], {BOUND_W{1'b1}}, ptr1[PTR_HI_LSB-1:0]};

  agusec_range u_range_low (
    .ptr       (ptr_lo_only),
    .sum       (s1),
    .cin_secq  (1'b1),
    .diff      (1'b0),
    .cout_secq (ge_low)
  );

  // wrapped window below the low bound sits in the region above the carry
  assign c_up = pos_flip[0] & ~ge_low;
  assign c_dn = neg_flip[0] & ge_low;

  assign ack   = b1[GADDR_W-1] ? neg_ack : pos_ack;
  assign agree = c_up ? ack[1] : (c_dn ? ack[2] : ack[0]);

  assign legal_d = ~en1 | pos_flip[1] | (neg_flip[1] & win_ok & agree);

  assign ptr_sum = {ptr1[PTR_W-1:PTR_ADDR_MSB+1], s1, ptr1[PTR_ADDR_LSB-1:0]};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rsp   <= 1'b0;
      fault <= 1'b0;
      legal <= 1'b0;
    end else begin
      rsp   <= v1;
      fault <= v1 & ~legal_d;
      if (v1) begin
        legal <= legal_d;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (v1) begin
      ptr_out <= ptr_sum;
    end
  end

endmodule

`default_nettype wire

/* hw/agusec_cfg.sv */
`timescale 1ns/10ps
`default_nettype none

module agusec_cfg
  import agusec_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic       cfg_wr,
  input  logic [1:0] cfg_addr,
  input  cfg_data_t  cfg_wdata,
  input  logic       fault,
  input  ptr_t       fault_ptr,
  output cfg_data_t  cfg_rdata,
  output logic       check_en
);

  cfg_data_t fault_cnt;
  ptr_t      last_ptr;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      check_en  <= 1'b1;
      fault_cnt <= '0;
      last_ptr  <= '0;
    end else begin
      if (cfg_wr && cfg_addr == CFG_CTRL) begin
        check_en <= cfg_wdata[0];
      end
      // a write clears the counter even when a fault arrives with it
      if (cfg_wr && cfg_addr == CFG_COUNT) begin
        fault_cnt <= '0;
      end else if (fault && fault_cnt != COUNT_MAX) begin
        fault_cnt <= fault_cnt + 1'b1;
      end
      if (fault) begin
        last_ptr <= fault_ptr;
      end
    end
  end

  always_comb begin
    case (cfg_addr)
      CFG_CTRL:   cfg_rdata = {{(CFG_W-1){1'b0}}, check_en};
      CFG_COUNT:  cfg_rdata = fault_cnt;
      CFG_PTR_LO: cfg_rdata = last_ptr[CFG_W-1:0];
      default:    cfg_rdata = last_ptr[PTR_W-1:CFG_W];
    endcase
  end

endmodule

`default_nettype wire

/* hw/agusec_top.sv */
`timescale 1ns/10ps
`default_nettype none

module agusec_top
  import agusec_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic       req,
  input  ptr_t       ptr,
  input  gaddr_t     a,
  input  gaddr_t     b,
  output logic       rsp,
  output logic       legal,
  output ptr_t       ptr_out,
  input  logic       cfg_wr,
  input  logic [1:0] cfg_addr,
  input  cfg_data_t  cfg_wdata,
  output cfg_data_t  cfg_rdata
);

  logic fault;
  logic check_en;

  agusec_unit u_unit (
    .clk      (clk),
    .arst_n   (arst_n),
    .req      (req),
    .ptr      (ptr),
    .a        (a),
    .b        (b),
    .check_en (check_en),
    .rsp      (rsp),
    .legal    (legal),
    .fault    (fault),
    .ptr_out  (ptr_out)
  );

  // faulting results feed the counter and the pointer capture
  agusec_cfg u_cfg (
    .clk       (clk),
    .arst_n    (arst_n),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .fault     (fault),
    .fault_ptr (ptr_out),
    .cfg_rdata (cfg_rdata),
    .check_en  (check_en)
  );

endmodule

`default_nettype wire

/* sim/agusec_chk.sv */
`timescale 1ns/10ps
`default_nettype none

module agusec_chk (
  input logic clk,
  input logic arst_n,
  input logic req,
  input logic rsp,
  input logic legal,
  input logic fault,
  input logic check_en
);

  int unsigned fail_cnt = 0;

  // each request gets its response two edges later
  req_to_rsp: assert property (@(posedge clk) disable iff (!arst_n) req |-> ##2 rsp)
    else begin
      $error("rsp missing two cycles after req");
      fail_cnt++;
    end

  rsp_from_req: assert property (@(posedge clk) disable iff (!arst_n) rsp |-> $past(req, 2))
    else begin
      $error("rsp without a request two cycles earlier");
      fail_cnt++;
    end

  fault_is_illegal: assert property (@(posedge clk) disable iff (!arst_n)
    fault |-> (rsp && !legal))
    else begin
      $error("fault without an illegal response");
      fail_cnt++;
    end

  rsp_low_in_reset: assert property (@(posedge clk) !arst_n |-> !rsp)
    else begin
      $error("rsp high during reset");
      fail_cnt++;
    end

  // enable comes out of reset set
  en_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> check_en)
    else begin
      $error("check_en low after reset");
      fail_cnt++;
    end

endmodule

`default_nettype wire

/* sim/agusec_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module agusec_tb
  import agusec_pkg::*;
();

  localparam int N_RAND = 400;
  localparam int N_MAX  = 50;
  localparam int N_EN   = 60;
  localparam int N_CNT  = 100;
  // at most five cycles per request, plus reads and drains
  localparam int TEST_CYCLES = 5 * (N_RAND + N_MAX + 2 * N_EN + N_CNT) + 80;
  localparam int CYCLE_LIMIT = 2 * TEST_CYCLES + 100;

  logic       clk;
  logic       arst_n;
  logic       req;
  ptr_t       ptr;
  gaddr_t     a;
  gaddr_t     b;
  logic       rsp;
  logic       legal;
  ptr_t       ptr_out;
  logic       cfg_wr;
  logic [1:0] cfg_addr;
  cfg_data_t  cfg_wdata;
  cfg_data_t  cfg_rdata;

  logic [63:0]    lfsr;
  logic [PTR_W:0] exp_q[$];
  string          test_name;
  int             test_errs;
  int             total_errs;
  int             tests_run;
  int             tests_failed;
  int             checks;
  int             n_legal;
  int             n_illegal;
  int             model_faults;
  ptr_t           model_last_ptr;
  logic           model_en;
  int             cycle_cnt;

  agusec_top UUT (
    .clk       (clk),
    .arst_n    (arst_n),
    .req       (req),
    .ptr       (ptr),
    .a         (a),
    .b         (b),
    .rsp       (rsp),
    .legal     (legal),
    .ptr_out   (ptr_out),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata)
  );

  bind agusec_unit agusec_chk u_chk (
    .clk      (clk),
    .arst_n   (arst_n),
    .req      (req),
    .rsp      (rsp),
    .legal    (legal),
    .fault    (fault),
    .check_en (check_en)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // taps 64, 63, 61, 60
  function automatic logic [63:0] lfsr_next(input logic [63:0] s);
    return {s[62:0], s[63] ^ s[62] ^ s[60] ^ s[59]};
  endfunction

  task automatic take_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[62:0], lfsr[0]};
    end
  endtask

  function automatic logic model_legal(input ptr_t p, input gaddr_t av, input gaddr_t bv,
                                       input logic en);
    gaddr_t      s;
    int          e;
    logic [7:0]  w;
    logic [7:0]  lw;
    logic [7:0]  hw;
    logic        wrap;
    logic        win_in;
    logic [63:0] c;
    logic [63:0] s_hi;
    logic [63:0] a_hi;
    logic [63:0] mask;
    s = av + bv;
    e = p[PTR_EXP_MSB:PTR_EXP_LSB];
    if (!en || e == EXP_MAX) begin
      return 1'b1;
    end
    w    = 8'(s >> e);
    lw   = {p[PTR_LOW_MSB:PTR_LOW_LSB], 1'b0};
    hw   = {p[PTR_HI_MSB:PTR_HI_LSB], 1'b1};
    wrap = p[PTR_HI_MSB:PTR_HI_LSB] < p[PTR_LOW_MSB:PTR_LOW_LSB];
    c = '0;
    if (wrap && !p[PTR_ON_LOW] && w <= hw) begin
      c = 64'd1;
    end
    if (wrap && p[PTR_ON_LOW] && w >= lw) begin
      c = '1;
    end
    win_in = wrap ? (w >= lw || w <= hw) : (w >= lw && w <= hw);
    s_hi = 64'(s) >> (e + 8);
    a_hi = 64'(av) >> (e + 8);
    mask = (64'd1 << (GADDR_W - e - 8)) - 64'd1;
    return win_in && (((s_hi - a_hi - c) & mask) == 64'd0);
  endfunction

  task automatic send(input ptr_t p, input gaddr_t av, input gaddr_t bv);
    logic lg;
    ptr_t po;
    lg = model_legal(p, av, bv, model_en);
    // same pointer with the address field holding the sum
    po = p;
    po[PTR_ADDR_MSB:PTR_ADDR_LSB] = av + bv;
    if (lg) begin
      n_legal++;
    end else begin
      n_illegal++;
      model_faults++;
      model_last_ptr = po;
    end
    exp_q.push_back({lg, po});
    req = 1'b1;
    ptr = p;
    a   = av;
    b   = bv;
    @(negedge clk);
    req = 1'b0;
  endtask

  task automatic rand_req(input logic force_max);
    logic [63:0] r;
    ptr_t        p;
    gaddr_t      av;
    gaddr_t      bv;
    take_bits(64, r);
    p = r;
    take_bits(40, r);
    av = r[39:0];
    take_bits(40, r);
    bv = r[39:0];
    if (force_max) begin
      p[PTR_EXP_MSB:PTR_EXP_LSB] = EXP_MAX;
    end else begin
      take_bits(5, r);
      p[PTR_EXP_MSB:PTR_EXP_LSB] = exp_t'(r[4:0] % 31);
      take_bits(2, r);
      // mostly offsets of a few windows, either sign
      if (r[1:0] == 2'd1 || r[1:0] == 2'd2) begin
        take_bits(10, r);
        bv = gaddr_t'(r[8:0]) << p[PTR_EXP_MSB:PTR_EXP_LSB];
        if (r[9]) begin
          bv = -bv;
        end
      end else if (r[1:0] == 2'd3) begin
        take_bits(6, r);
        bv = {{34{r[5]}}, r[5:0]};
      end
    end
    send(p, av, bv);
  endtask

  task automatic run_random(input int n, input logic force_max);
    logic [63:0] r;
    for (int i = 0; i < n; i++) begin
      rand_req(force_max);
      take_bits(2, r);
      if (r[1:0] == 2'd3) begin
        take_bits(2, r);
        repeat (r[1:0] + 1) @(negedge clk);
      end
    end
  endtask

  task automatic drain();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (2) @(negedge clk);
  endtask

  task automatic cfg_write(input logic [1:0] ad, input cfg_data_t d);
    cfg_wr    = 1'b1;
    cfg_addr  = ad;
    cfg_wdata = d;
    @(negedge clk);
    cfg_wr = 1'b0;
    if (ad == CFG_CTRL) begin
      model_en = d[0];
    end
    if (ad == CFG_COUNT) begin
      model_faults = 0;
    end
  endtask

  task automatic cfg_expect(input logic [1:0] ad, input cfg_data_t want, input string what);
    cfg_addr = ad;
    #1;
    checks++;
    if (cfg_rdata !== want) begin
      $display("FAILED %s: %s expected %h actual %h", test_name, what, want, cfg_rdata);
      test_errs++;
    end
    @(negedge clk);
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errs = 0;
    n_legal   = 0;
    n_illegal = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errs == 0) begin
      $display("test %s: passed", test_name);
    end else begin
      $display("test %s: %0d errors", test_name, test_errs);
      tests_failed++;
      total_errs += test_errs;
    end
  endtask

  // compare each response with the oldest model result
  always @(negedge clk) begin
    logic [PTR_W:0] want;
    if (arst_n && rsp) begin
      if (exp_q.size() == 0) begin
        $display("FAILED %s: rsp appeared with no request outstanding", test_name);
        test_errs++;
      end else begin
        want = exp_q.pop_front();
        checks++;
        if (legal !== want[PTR_W]) begin
          $display("FAILED %s: legal expected %0b actual %0b", test_name, want[PTR_W], legal);
          test_errs++;
        end
        if (ptr_out !== want[PTR_W-1:0]) begin
          $display("FAILED %s: ptr_out expected %h actual %h", test_name,
                   want[PTR_W-1:0], ptr_out);
          test_errs++;
        end
      end
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("run stopped after %0d cycles without finishing", cycle_cnt);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    lfsr           = 64'd72;
    arst_n         = 1'b0;
    req            = 1'b0;
    ptr            = '0;
    a              = '0;
    b              = '0;
    cfg_wr         = 1'b0;
    cfg_addr       = CFG_CTRL;
    cfg_wdata      = '0;
    model_en       = 1'b1;
    model_faults   = 0;
    model_last_ptr = '0;
    total_errs     = 0;
    tests_run      = 0;
    tests_failed   = 0;
    checks         = 0;
    start_test("reset");
    repeat (2) @(negedge clk);
    arst_n = 1'b1;

    cfg_expect(CFG_CTRL, 32'd1, "enable");
    cfg_expect(CFG_COUNT, 32'd0, "fault count");
    cfg_expect(CFG_PTR_LO, 32'd0, "pointer low");
    cfg_expect(CFG_PTR_HI, 32'd0, "pointer high");
    repeat (10) @(negedge clk);
    end_test();

    start_test("random");
    run_random(N_RAND, 1'b0);
    drain();
    if (n_legal == 0 || n_illegal == 0) begin
      $display("test %s did not produce both legal and illegal results", test_name);
      test_errs++;
    end
    end_test();

    start_test("exp_max");
    run_random(N_MAX, 1'b1);
    drain();
    end_test();

    start_test("enable");
    cfg_write(CFG_CTRL, 32'd0);
    cfg_expect(CFG_CTRL, 32'd0, "enable");
    run_random(N_EN, 1'b0);
    drain();
    cfg_write(CFG_CTRL, 32'd1);
    cfg_expect(CFG_CTRL, 32'd1, "enable");
    run_random(N_EN, 1'b0);
    drain();
    end_test();

    start_test("fault_count");
    cfg_write(CFG_COUNT, 32'd0);
    cfg_expect(CFG_COUNT, 32'd0, "fault count");
    run_random(N_CNT, 1'b0);
    drain();
    cfg_expect(CFG_COUNT, cfg_data_t'(model_faults), "fault count");
    cfg_expect(CFG_PTR_LO, model_last_ptr[CFG_W-1:0], "pointer low");
    cfg_expect(CFG_PTR_HI, model_last_ptr[PTR_W-1:CFG_W], "pointer high");
    cfg_write(CFG_COUNT, 32'd0);
    cfg_expect(CFG_COUNT, 32'd0, "fault count");
    end_test();

    if (UUT.u_unit.u_chk.fail_cnt != 0) begin
      $display("%0d assertion failures in the unit checker", UUT.u_unit.u_chk.fail_cnt);
      total_errs += UUT.u_unit.u_chk.fail_cnt;
    end
    $display("tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, total_errs);
    if (total_errs == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
hw/agusec_pkg.sv
hw/agusec_check_upper3.sv
hw/agusec_range.sv
hw/agusec_unit.sv
hw/agusec_cfg.sv
hw/agusec_top.sv
sim/agusec_chk.sv
sim/agusec_tb.sv
